// File: all.f
logic/csr_pkg.sv
logic/csr_op_pkg.sv
logic/csr_op_unit.sv
logic/machine_timer.sv
logic/csr_file.sv
logic/trap_subsystem.sv
tb/trap_subsystem_properties.sv
tb/tb_trap_subsystem.sv

// File: logic/csr_file.sv
`timescale 1ns/100ps

module csr_file
	import csr_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// timer interrupt level.
	input logic i_interrupt,

	// access from the CSR instruction unit.
	input csr_index_t i_index,
	output csr_data_t o_rdata,
	output logic o_index_known,
	input logic i_wr,
	input csr_data_t i_wdata,

	// timer registers, held in the timer and only read back here.
	input csr_data_t i_mtime,
	input csr_data_t i_mtimecmp,

	output csr_data_t o_epc,

	// trap request towards the pipeline.
	output logic o_irq_pending,
	output csr_data_t o_irq_pc,
	input logic i_irq_dispatched,
	input csr_data_t i_irq_epc
);

	logic mie_mtie;
	logic mip_mtip;
	csr_data_t mtvec;
	csr_data_t mepc;
	csr_data_t mcause;
	csr_data_t mie_value;
	csr_data_t mip_value;
	logic take_irq;

	// mie and mip hold a single live bit each.
	always_comb begin
		mie_value = '0;
		mie_value[MIE_MTIE_BIT] = mie_mtie;
		mip_value = '0;
		mip_value[MIE_MTIE_BIT] = mip_mtip;
	end

	assign o_epc = mepc;

	always_comb begin
		o_rdata = '0;
		o_index_known = 1'b1;
		case (i_index)
			CSR_MIE: o_rdata = mie_value;
			CSR_MTVEC: o_rdata = mtvec;
			CSR_MEPC: o_rdata = mepc;
			CSR_MCAUSE: o_rdata = mcause;
			CSR_MIP: o_rdata = mip_value;
			CSR_MVENDORID: o_rdata = CSR_IDENTITY_VALUE;
			CSR_MARCHID: o_rdata = CSR_IDENTITY_VALUE;
			CSR_MIMPID: o_rdata = CSR_IDENTITY_VALUE;
			CSR_MHARTID: o_rdata = CSR_IDENTITY_VALUE;
			CSR_MTIME: o_rdata = i_mtime;
			CSR_MTIMECMP: o_rdata = i_mtimecmp;
			default: o_index_known = 1'b0;
		endcase
	end

	// software writes to the enable and the vector.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mie_mtie <= 1'b0;
			mtvec <= CSR_RESET_VALUE;
		end else if (i_wr) begin
			if (i_index == CSR_MIE) begin
				mie_mtie <= i_wdata[MIE_MTIE_BIT];
			end
			if (i_index == CSR_MTVEC) begin
				mtvec <= i_wdata;
			end
		end
	end

	// a new trap is only taken while none is waiting for dispatch.
	assign take_irq = i_interrupt && mie_mtie && !o_irq_pending;

	// The trap sequence outranks software writes to mcause and mepc.
	// A dispatch in the same cycle as a new take wins, and the level
	// is sampled again on the following edge.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_irq_pending <= 1'b0;
			mip_mtip <= 1'b0;
			mcause <= CSR_RESET_VALUE;
			mepc <= CSR_RESET_VALUE;
		end else begin
			if (i_wr && i_index == CSR_MCAUSE) begin
				mcause <= i_wdata;
			end
			if (i_wr && i_index == CSR_MEPC) begin
				mepc <= i_wdata;
			end

			if (take_irq) begin
				o_irq_pending <= 1'b1;
				mip_mtip <= 1'b1;
				mcause <= CAUSE_TIMER_IRQ;
			end

			if (i_irq_dispatched) begin
				o_irq_pending <= 1'b0;
				mip_mtip <= 1'b0;
				mepc <= i_irq_epc;
			end
		end
	end

	// the handler address is captured with the trap itself.
	always_ff @(posedge i_clock) begin
		if (take_irq) begin
			o_irq_pc <= mtvec;
		end
	end

endmodule

// File: logic/csr_op_pkg.sv
package csr_op_pkg;

	// low two bits of funct3 for the register forms of the CSR instructions.
	typedef enum logic [1:0] {
		CSR_OP_RW = 2'b01,
		CSR_OP_RS = 2'b10,
		CSR_OP_RC = 2'b11
	} csr_op_t;

	// bits 11:10 of a CSR index give its access class.
	// all ones there marks the read-only range.
	localparam int CSR_RO_FIELD_HI = 11;
	localparam int CSR_RO_FIELD_LO = 10;

endpackage

// File: logic/csr_op_unit.sv
`timescale 1ns/100ps

module csr_op_unit
	import csr_pkg::*, csr_op_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// one CSR instruction per cycle, no back-pressure.
	input logic i_valid,
	input csr_op_t i_op,
	input csr_index_t i_index,
	input csr_data_t i_operand,

	// combinational read port of the CSR file.
	input csr_data_t i_csr_rdata,
	input logic i_index_known,
	output csr_index_t o_csr_index,

	// write strobe seen by the CSR file and the timer alike.
	output logic o_wr,
	output csr_data_t o_wdata,

	// completion, one cycle after the request.
	output logic o_done,
	output csr_data_t o_result,
	output logic o_illegal
);

	logic ro_index;
	logic write_attempt;
	logic illegal;
	csr_data_t new_value;

	// the read happens on the request's own index, in the same cycle.
	assign o_csr_index = i_index;

	assign ro_index = &i_index[CSR_RO_FIELD_HI:CSR_RO_FIELD_LO];

	always_comb begin
		new_value = i_csr_rdata;
		write_attempt = 1'b0;
		case (i_op)
			CSR_OP_RW: begin
				// csrrw always counts as a write, even of zero.
				new_value = i_operand;
				write_attempt = 1'b1;
			end
			CSR_OP_RS: begin
				new_value = i_csr_rdata | i_operand;
				write_attempt = |i_operand;
			end
			CSR_OP_RC: begin
				new_value = i_csr_rdata & ~i_operand;
				write_attempt = |i_operand;
			end
			default: begin
				write_attempt = 1'b0;
			end
		endcase
	end

	assign illegal = !i_index_known || (write_attempt && ro_index);

	assign o_wr = i_valid && write_attempt && !illegal;
	assign o_wdata = new_value;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_done <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			o_done <= i_valid;
			o_illegal <= i_valid && illegal;
		end
	end

	// an illegal request hands back zero instead of the old value.
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_result <= illegal ? '0 : i_csr_rdata;
		end
	end

endmodule

// File: logic/csr_pkg.sv
package csr_pkg;

	// widths of a CSR address and a CSR value.
	localparam int CSR_INDEX_WIDTH = 12;
	localparam int CSR_DATA_WIDTH = 32;

	typedef logic [CSR_INDEX_WIDTH-1:0] csr_index_t;
	typedef logic [CSR_DATA_WIDTH-1:0] csr_data_t;

	// standard machine-mode CSR indices.
	localparam csr_index_t CSR_MIE = 12'h304;
	localparam csr_index_t CSR_MTVEC = 12'h305;
	localparam csr_index_t CSR_MEPC = 12'h341;
	localparam csr_index_t CSR_MCAUSE = 12'h342;
	localparam csr_index_t CSR_MIP = 12'h344;

	// identity registers, all of them read as zero on this core.
	localparam csr_index_t CSR_MVENDORID = 12'hF11;
	localparam csr_index_t CSR_MARCHID = 12'hF12;
	localparam csr_index_t CSR_MIMPID = 12'hF13;
	localparam csr_index_t CSR_MHARTID = 12'hF14;

	// the timer lives in the custom read/write machine range.
	localparam csr_index_t CSR_MTIME = 12'h7C0;
	localparam csr_index_t CSR_MTIMECMP = 12'h7C1;

	// timer enable in mie and timer pending in mip share this position.
	localparam int MIE_MTIE_BIT = 7;

	// interrupt flag in bit 31, machine timer interrupt code 7.
	localparam csr_data_t CAUSE_TIMER_IRQ = 32'h8000_0007;

	localparam csr_data_t CSR_RESET_VALUE = '0;
	localparam csr_data_t CSR_IDENTITY_VALUE = '0;
	localparam csr_data_t MTIME_RESET = '0;
	// compare at the top of the range, so the timer stays quiet after reset.
	localparam csr_data_t MTIMECMP_RESET = '1;

endpackage

// File: logic/machine_timer.sv
`timescale 1ns/100ps

module machine_timer
	import csr_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// shared CSR write strobe, only mtimecmp is taken here.
	input logic i_wr,
	input csr_index_t i_index,
	input csr_data_t i_wdata,

	output csr_data_t o_mtime,
	output csr_data_t o_mtimecmp,
	output logic o_timer_irq
);

	logic cmp_write;
	csr_data_t mtime_next;
	csr_data_t mtimecmp_next;

	assign cmp_write = i_wr && (i_index == CSR_MTIMECMP);

	// the counter wraps silently at 32 bits.
	assign mtime_next = o_mtime + 1'b1;
	assign mtimecmp_next = cmp_write ? i_wdata : o_mtimecmp;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_mtime <= MTIME_RESET;
		end else begin
			o_mtime <= mtime_next;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_mtimecmp <= MTIMECMP_RESET;
		end else begin
			o_mtimecmp <= mtimecmp_next;
		end
	end

	// The comparison is made on the next-state values, so the registered
	// level always agrees with the mtime and mtimecmp shown beside it.
	// A compare write therefore moves the level in the following cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_timer_irq <= 1'b0;
		end else begin
			o_timer_irq <= (mtime_next >= mtimecmp_next);
		end
	end

endmodule

// File: logic/trap_subsystem.sv
`timescale 1ns/100ps

module trap_subsystem
	import csr_pkg::*, csr_op_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic i_valid,
	input csr_op_t i_op,
	input csr_index_t i_index,
	input csr_data_t i_operand,
	output logic o_done,
	output csr_data_t o_result,
	output logic o_illegal,

	output logic o_irq_pending,
	output csr_data_t o_irq_pc,
	input logic i_irq_dispatched,
	input csr_data_t i_irq_epc,
	output csr_data_t o_epc
);

	csr_index_t csr_index;
	csr_data_t csr_rdata;
	logic index_known;
	logic csr_wr;
	csr_data_t csr_wdata;
	csr_data_t mtime;
	csr_data_t mtimecmp;
	logic timer_irq;

	csr_op_unit i_csr_op_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_op(i_op),
		.i_index(i_index),
		.i_operand(i_operand),
		.i_csr_rdata(csr_rdata),
		.i_index_known(index_known),
		.o_csr_index(csr_index),
		.o_wr(csr_wr),
		.o_wdata(csr_wdata),
		.o_done(o_done),
		.o_result(o_result),
		.o_illegal(o_illegal)
	);

	// the timer snoops the same write strobe as the CSR file.
	machine_timer i_machine_timer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_wr(csr_wr),
		.i_index(csr_index),
		.i_wdata(csr_wdata),
		.o_mtime(mtime),
		.o_mtimecmp(mtimecmp),
		.o_timer_irq(timer_irq)
	);

	csr_file i_csr_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_interrupt(timer_irq),
		.i_index(csr_index),
		.o_rdata(csr_rdata),
		.o_index_known(index_known),
		.i_wr(csr_wr),
		.i_wdata(csr_wdata),
		.i_mtime(mtime),
		.i_mtimecmp(mtimecmp),
		.o_epc(o_epc),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_trap_subsystem \
	-f all.f -o sim_trap_subsystem > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_trap_subsystem +verilator+error+limit+1000 > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation ended without a result, see sim.log"; exit 1; }

// File: tb/tb_trap_subsystem.sv
`timescale 1ns/100ps

module tb_trap_subsystem
	import csr_pkg::*, csr_op_pkg::*;
();

	localparam int MEM_DEPTH = 256;
	localparam int FIRST_REQUEST = 3;
	localparam int DONE_WAIT = 4;
	localparam int IRQ_WINDOW = 16;

	logic i_clock;
	logic i_reset;
	logic i_valid;
	csr_op_t i_op;
	csr_index_t i_index;
	csr_data_t i_operand;
	logic o_done;
	csr_data_t o_result;
	logic o_illegal;
	logic o_irq_pending;
	csr_data_t o_irq_pc;
	logic i_irq_dispatched;
	csr_data_t i_irq_epc;
	csr_data_t o_epc;

	logic [31:0] test_mem [0:MEM_DEPTH-1];
	csr_data_t scen_mtvec;
	csr_data_t scen_mtimecmp;
	csr_data_t scen_epc;
	int request_count;
	int timeout_limit = 1000;
	int cycle_count;
	int error_count;
	int check_count;
	int test_count;
	int test_errors_start;

	trap_subsystem i_trap_subsystem (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_op(i_op),
		.i_index(i_index),
		.i_operand(i_operand),
		.o_done(o_done),
		.o_result(o_result),
		.o_illegal(o_illegal),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_epc(o_epc)
	);

	bind trap_subsystem trap_subsystem_properties i_trap_subsystem_properties (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.o_done(o_done),
		.o_illegal(o_illegal),
		.o_irq_pending(o_irq_pending),
		.i_irq_dispatched(i_irq_dispatched)
	);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= timeout_limit) begin
			@(posedge i_clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the run did not complete", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// all tasks start and end 2 ns after a rising edge.
	task automatic issue_request(input csr_op_t op, input csr_index_t index,
			input csr_data_t operand, output csr_data_t result, output logic illegal,
			output logic done_seen);
		int waited;
		i_valid = 1'b1;
		i_op = op;
		i_index = index;
		i_operand = operand;
		@(posedge i_clock);
		#2;
		i_valid = 1'b0;
		waited = 0;
		while (!o_done && waited < DONE_WAIT) begin
			@(posedge i_clock);
			#2;
			waited++;
		end
		done_seen = o_done;
		result = o_result;
		illegal = o_illegal;
	endtask

	task automatic check_request(input int num, input csr_op_t op, input csr_index_t index,
			input csr_data_t operand, input csr_data_t exp_result, input logic exp_illegal);
		csr_data_t result;
		logic illegal;
		logic done_seen;
		issue_request(op, index, operand, result, illegal, done_seen);
		check_count++;
		if (!done_seen) begin
			$display("request %0d on index %h never signalled done", num, index);
			error_count++;
		end else begin
			if (result !== exp_result) begin
				$display("[ERROR] o_result request %0d index %h expected %h got %h",
					num, index, exp_result, result);
				error_count++;
			end
			if (illegal !== exp_illegal) begin
				$display("[ERROR] o_illegal request %0d index %h expected %h got %h",
					num, index, exp_illegal, illegal);
				error_count++;
			end
		end
	endtask

	// a legal write whose old value is of no interest here.
	task automatic write_csr(input csr_index_t index, input csr_data_t value);
		csr_data_t result;
		logic illegal;
		logic done_seen;
		issue_request(CSR_OP_RW, index, value, result, illegal, done_seen);
		check_count++;
		if (!done_seen || illegal) begin
			$display("write of %h to index %h was not completed as a legal request",
				value, index);
			error_count++;
		end
	endtask

	task automatic wait_pending(input int window, output logic seen);
		int waited;
		waited = 0;
		seen = o_irq_pending;
		while (!seen && waited < window) begin
			@(posedge i_clock);
			#2;
			waited++;
			seen = o_irq_pending;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d %s finished with %0d errors", test_count, name,
			error_count - test_errors_start);
		test_errors_start = error_count;
	endtask

	initial begin
		int addr;
		csr_data_t first_time;
		csr_data_t second_time;
		logic seen;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_op = CSR_OP_RW;
		i_index = '0;
		i_operand = '0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = '0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		test_errors_start = 0;

		$readmemh("tb/trap_testdata.txt", test_mem);
		scen_mtvec = test_mem[0];
		scen_mtimecmp = test_mem[1];
		scen_epc = test_mem[2];
		request_count = 0;
		addr = FIRST_REQUEST;
		while (addr + 4 < MEM_DEPTH && test_mem[addr] != 0) begin
			request_count++;
			addr += 5;
		end
		// each request may take DONE_WAIT + 1 cycles.
		// the interrupt windows and the fixed steps of the later tests fit in the rest.
		timeout_limit = request_count * (DONE_WAIT + 1) + 4 * IRQ_WINDOW + 100;

		repeat (2) @(posedge i_clock);
		#2;
		i_reset = 1'b0;

		for (int n = 0; n < request_count; n++) begin
			addr = FIRST_REQUEST + 5 * n;
			check_request(n, csr_op_t'(test_mem[addr][1:0]), test_mem[addr + 1][11:0],
				test_mem[addr + 2], test_mem[addr + 3], test_mem[addr + 4][0]);
		end
		finish_test("csr requests from data file");

		// two reads in consecutive cycles see consecutive counter values.
		i_valid = 1'b1;
		i_op = CSR_OP_RS;
		i_index = CSR_MTIME;
		i_operand = '0;
		@(posedge i_clock);
		#2;
		first_time = o_result;
		seen = o_done;
		@(posedge i_clock);
		#2;
		i_valid = 1'b0;
		second_time = o_result;
		check_count++;
		if (!seen || !o_done) begin
			$display("back-to-back mtime reads did not both signal done");
			error_count++;
		end else if (second_time !== first_time + 32'd1) begin
			$display("[ERROR] o_result second mtime read expected %h got %h",
				first_time + 32'd1, second_time);
			error_count++;
		end
		finish_test("mtime back-to-back reads");

		write_csr(CSR_MTVEC, scen_mtvec);
		write_csr(CSR_MTIMECMP, scen_mtimecmp);
		write_csr(CSR_MIE, 32'h0000_0080);
		wait_pending(IRQ_WINDOW, seen);
		check_count++;
		if (!seen) begin
			$display("timer interrupt did not raise o_irq_pending within %0d cycles",
				IRQ_WINDOW);
			error_count++;
		end else if (o_irq_pc !== scen_mtvec) begin
			$display("[ERROR] o_irq_pc expected %h got %h", scen_mtvec, o_irq_pc);
			error_count++;
		end
		check_request(100, CSR_OP_RS, CSR_MCAUSE, '0, CAUSE_TIMER_IRQ, 1'b0);
		check_request(101, CSR_OP_RS, CSR_MIP, '0, 32'h0000_0080, 1'b0);
		finish_test("timer interrupt");

		// the compare reset shares the dispatch cycle so no new trap is taken.
		i_irq_dispatched = 1'b1;
		i_irq_epc = scen_epc;
		i_valid = 1'b1;
		i_op = CSR_OP_RW;
		i_index = CSR_MTIMECMP;
		i_operand = 32'hFFFF_FFFF;
		@(posedge i_clock);
		#2;
		i_irq_dispatched = 1'b0;
		i_valid = 1'b0;
		check_count++;
		if (o_irq_pending !== 1'b0) begin
			$display("[ERROR] o_irq_pending expected %h got %h", 1'b0, o_irq_pending);
			error_count++;
		end
		if (o_epc !== scen_epc) begin
			$display("[ERROR] o_epc expected %h got %h", scen_epc, o_epc);
			error_count++;
		end
		if (!o_done) begin
			$display("mtimecmp write in the dispatch cycle never signalled done");
			error_count++;
		end else if (o_result !== scen_mtimecmp) begin
			$display("[ERROR] o_result mtimecmp write expected %h got %h",
				scen_mtimecmp, o_result);
			error_count++;
		end
		check_request(102, CSR_OP_RS, CSR_MEPC, '0, scen_epc, 1'b0);
		check_request(103, CSR_OP_RS, CSR_MIP, '0, 32'h0000_0000, 1'b0);
		finish_test("interrupt dispatch");

		write_csr(CSR_MIE, 32'h0000_0000);
		write_csr(CSR_MTIMECMP, scen_mtimecmp);
		wait_pending(IRQ_WINDOW, seen);
		check_count++;
		if (seen) begin
			$display("o_irq_pending rose while the timer interrupt was disabled");
			error_count++;
		end
		finish_test("masked timer interrupt");

		repeat (2) @(posedge i_clock);
		error_count += i_trap_subsystem.i_trap_subsystem_properties.failures;
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: tb/trap_subsystem_properties.sv
`timescale 1ns/100ps

module trap_subsystem_properties (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic o_done,
	input logic o_illegal,
	input logic o_irq_pending,
	input logic i_irq_dispatched
);

	// the testbench adds this count to its own error total.
	int failures;

	initial failures = 0;

	// each done answers the request of the cycle before it.
	done_follows_valid: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_done && $past(o_done)) |-> ($past(i_valid) && $past(i_valid, 2)))
		else begin
			$error("o_done high in two cycles without two requests");
			failures++;
		end

	illegal_with_done: assert property (@(posedge i_clock) disable iff (i_reset)
		o_illegal |-> o_done)
		else begin
			$error("o_illegal high without o_done");
			failures++;
		end

	// a dispatch always clears the pending trap at the next edge.
	dispatch_clears_pending: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |=> !o_irq_pending)
		else begin
			$error("o_irq_pending still high after i_irq_dispatched");
			failures++;
		end

endmodule

// File: tb/trap_testdata.txt
// first line: interrupt scenario mtvec, mtimecmp, dispatch epc
// then one request per line: op index operand expected_result expected_illegal
// op 1 = rw, 2 = rs, 3 = rc, op 0 ends the list
00000400 00000010 00000A3C
1 305 00000100 00000000 0
2 305 00000011 00000100 0
3 305 00000001 00000111 0
2 305 00000000 00000110 0
3 305 00000000 00000110 0
1 305 00000200 00000110 0
1 304 FFFFFFFF 00000000 0
2 304 00000000 00000080 0
3 304 00000080 00000080 0
2 304 00000080 00000000 0
3 304 FFFFFFFF 00000080 0
2 304 00000000 00000000 0
2 F11 00000000 00000000 0
3 F12 00000000 00000000 0
2 F13 00000000 00000000 0
3 F14 00000000 00000000 0
1 F14 00000005 00000000 1
2 F11 00000001 00000000 1
2 123 00000000 00000000 1
1 123 0000ABCD 00000000 1
1 7C1 00001234 FFFFFFFF 0
2 7C1 00000000 00001234 0
1 344 FFFFFFFF 00000000 0
2 344 00000000 00000000 0
1 342 0000000B 00000000 0
2 342 00000000 0000000B 0
1 341 00000080 00000000 0
3 341 00000000 00000080 0
0 000 00000000 00000000 0
